// File: common/ks10Pkg.sv
package ks10Pkg;

   localparam int wordWidth   = 36;  // PDP-10 word, bit 35 is the MSB
   localparam int byteWidth   = 8;   // Console bus byte
   localparam int wordBytes   = 5;   // Console bytes per word
   localparam int memAddrBits = 16;  // Staged address, hi and lo bytes

   typedef logic [wordWidth-1:0] word_t;

   // Memory opcodes carried in the command byte
   typedef enum logic [1:0] {
      memNone  = 2'd0,
      memRead  = 2'd1,
      memWrite = 2'd2
   } memOp_t;

   // Single word access sequencer
   typedef enum logic [1:0] {
      stIdle,
      stReadAddr,         // Address presented to SSRAM
      stReadCapture,      // SSRAM data valid this cycle
      stWrite             // One cycle write strobe
   } memState_t;

   // Byte idx of a word as seen on the console, 0 is the top nibble byte
   function automatic logic [byteWidth-1:0] wordByte(word_t w, int unsigned idx);
      logic [byteWidth*wordBytes-1:0] wide;
      wide = {{(byteWidth*wordBytes-wordWidth){1'b0}}, w};
      return wide[byteWidth*(wordBytes-1-idx) +: byteWidth];
   endfunction

   // Same word with console byte idx replaced
   function automatic word_t setWordByte(word_t w, int unsigned idx,
                                         logic [byteWidth-1:0] b);
      logic [byteWidth*wordBytes-1:0] wide;
      wide = {{(byteWidth*wordBytes-wordWidth){1'b0}}, w};
      wide[byteWidth*(wordBytes-1-idx) +: byteWidth] = b;
      return wide[wordWidth-1:0];  // Top nibble byte keeps only bits 35:32
   endfunction

endpackage

// File: common/cslPkg.sv
package cslPkg;

   typedef logic [7:0] cslByte_t;  // One console bus byte

   localparam int statWidth = 24;  // Status register width

   // Console register map
   typedef enum logic [7:0] {
      regAddrHi = 8'h20,  // Memory address bits 15:8
      regAddrLo = 8'h21,  // Memory address bits 7:0
      regStat0  = 8'h25,  // Status bits 23:16
      regStat1  = 8'h26,
      regStat2  = 8'h27,  // Status bits 7:0, holds run and intr enable
      regCmd    = 8'h28,  // Memory command, write only
      regIntr   = 8'h29,  // Busy, done and pending flags
      regData0  = 8'h30,  // Data bits 35:32 in low nibble
      regData1  = 8'h31,
      regData2  = 8'h32,
      regData3  = 8'h33,
      regData4  = 8'h34   // Data bits 7:0
   } cslReg_t;

   // Status register bits
   localparam int statRunBit    = 0;
   localparam int statIntrEnBit = 1;

   // Bits of the regIntr byte
   localparam int intrBusyBit = 0;
   localparam int intrDoneBit = 1;
   localparam int intrPendBit = 2;

endpackage

// File: console/cslBus.sv
`timescale 1ns/1ps

module cslBus
(
   input  logic             clk,
   input  logic             reset,
   input  cslPkg::cslByte_t cslADIN,
   input  logic             cslALE,
   input  logic             cslRD_N,
   input  logic             cslWR_N,
   output cslPkg::cslByte_t regAddr,
   output cslPkg::cslByte_t wrData,
   output logic             wrStrobe,
   output logic             rdStrobe,
   output logic             rdActive
);

   import cslPkg::*;

   logic [1:0] aleSync;  // Two flop synchronizers
   logic [1:0] rdSync;
   logic [1:0] wrSync;
   cslByte_t   adSync0;  // AD bus delayed to match the strobes
   cslByte_t   adSync1;
   logic       rdLast;   // Previous synchronized levels
   logic       wrLast;

   // Strobes idle high, ALE idles low
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         aleSync <= 2'b00;
         rdSync  <= 2'b11;
         wrSync  <= 2'b11;
      end
      else
      begin
         aleSync <= {aleSync[0], cslALE};
         rdSync  <= {rdSync[0], cslRD_N};
         wrSync  <= {wrSync[0], cslWR_N};
      end
   end

   // Data rides along with the control pipeline
   always_ff @(posedge clk)
   begin
      adSync0 <= cslADIN;
      adSync1 <= adSync0;
   end

   // Address latch, transparent while ALE is high
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         regAddr <= '0;
      else if (aleSync[1])
         regAddr <= adSync1;
   end

   // Write data follows the bus while WR_N is low, frozen at the edge
   always_ff @(posedge clk)
   begin
      if (!wrSync[1])
         wrData <= adSync1;
   end

   // Rising edges of the synchronized strobes become one cycle pulses
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rdLast   <= 1'b1;
         wrLast   <= 1'b1;
         rdStrobe <= 1'b0;
         wrStrobe <= 1'b0;
      end
      else
      begin
         rdLast   <= rdSync[1];
         wrLast   <= wrSync[1];
         rdStrobe <= rdSync[1] & ~rdLast;  // End of a read cycle
         wrStrobe <= wrSync[1] & ~wrLast;  // End of a write cycle
      end
   end

   assign rdActive = ~rdSync[1];  // Host is reading

endmodule

// File: console/cslStatus.sv
`timescale 1ns/1ps

module cslStatus
(
   input  logic                         clk,
   input  logic                         reset,
   input  cslPkg::cslByte_t             regAddr,
   input  cslPkg::cslByte_t             wrData,
   input  logic                         wrStrobe,
   output logic [cslPkg::statWidth-1:0] statusReg,
   output logic                         runLED,
   output logic                         intrEnable
);

   import cslPkg::*;

   // Byte writes, regStat0 is the most significant byte
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         statusReg <= '0;
      else if (wrStrobe)
      begin
         case (regAddr)
            regStat0:
               statusReg[23:16] <= wrData;
            regStat1:
               statusReg[15:8]  <= wrData;
            regStat2:
               statusReg[7:0]   <= wrData;  // Run and intr enable live here
            default:
               ;                            // Not ours
         endcase
      end
   end

   assign runLED     = statusReg[statRunBit];     // Lit while CPU would run
   assign intrEnable = statusReg[statIntrEnBit];  // Gates cslINTR_N

endmodule

// File: console/cslRespond.sv
`timescale 1ns/1ps

module cslRespond
(
   input  logic                           clk,
   input  logic                           reset,
   input  cslPkg::cslByte_t               regAddr,
   input  logic                           rdStrobe,
   input  logic                           rdActive,
   input  logic [cslPkg::statWidth-1:0]   statusReg,
   input  logic                           intrEnable,
   input  logic [ks10Pkg::memAddrBits-1:0] memAddr,
   input  ks10Pkg::word_t                 memData,
   input  logic                           busy,
   input  logic                           doneStrobe,
   output cslPkg::cslByte_t               cslADOUT,
   output logic                           cslADOE,
   output logic                           cslINTR_N
);

   import ks10Pkg::*;
   import cslPkg::*;

   logic     doneFlag;  // Operation finished since last regIntr read
   logic     pendFlag;  // Same, but only when interrupts are enabled
   cslByte_t intrByte;
   cslByte_t readMux;
   cslByte_t readByte;  // Held read-back byte

   always_comb
   begin
      intrByte              = '0;
      intrByte[intrBusyBit] = busy;
      intrByte[intrDoneBit] = doneFlag;
      intrByte[intrPendBit] = pendFlag;
   end

   // Unmapped and write only addresses read zero
   always_comb
   begin
      case (regAddr)
         regAddrHi: readMux = memAddr[15:8];
         regAddrLo: readMux = memAddr[7:0];
         regStat0:  readMux = statusReg[23:16];
         regStat1:  readMux = statusReg[15:8];
         regStat2:  readMux = statusReg[7:0];
         regIntr:   readMux = intrByte;
         regData0:  readMux = wordByte(memData, 0);  // Bits 35:32 only
         regData1:  readMux = wordByte(memData, 1);
         regData2:  readMux = wordByte(memData, 2);
         regData3:  readMux = wordByte(memData, 3);
         regData4:  readMux = wordByte(memData, 4);
         default:   readMux = '0;
      endcase
   end

   // Sample while the host holds RD_N low
   always_ff @(posedge clk)
   begin
      if (rdActive)
         readByte <= readMux;
   end

   // Reading regIntr acknowledges, a new completion in the same cycle wins
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         doneFlag <= 1'b0;
         pendFlag <= 1'b0;
      end
      else if (doneStrobe)
      begin
         doneFlag <= 1'b1;
         pendFlag <= intrEnable;
      end
      else if (rdStrobe && regAddr == regIntr)
      begin
         doneFlag <= 1'b0;
         pendFlag <= 1'b0;
      end
   end

   assign cslADOUT  = readByte;
   assign cslADOE   = rdActive;   // Drive AD only during a read
   assign cslINTR_N = ~pendFlag;  // Active low interrupt

endmodule

// File: source/memAccess.sv
`timescale 1ns/1ps

module memAccess
#(
   parameter int addrWidth = 15
)
(
   input  logic                            clk,
   input  logic                            reset,
   input  cslPkg::cslByte_t                regAddr,
   input  cslPkg::cslByte_t                wrData,
   input  logic                            wrStrobe,
   output logic [ks10Pkg::memAddrBits-1:0] memAddr,
   output ks10Pkg::word_t                  memData,
   output logic                            busy,
   output logic                            doneStrobe,
   output logic [addrWidth-1:0]            ssramADDR,
   output ks10Pkg::word_t                  ssramDOUT,
   input  ks10Pkg::word_t                  ssramDIN,
   output logic                            ssramWR
);

   import ks10Pkg::*;
   import cslPkg::*;

   memState_t state;
   memState_t nextState;
   memOp_t    cmdOp;    // Decoded command byte
   logic      cmdWrite; // Host wrote regCmd this cycle

   assign cmdWrite = wrStrobe && (regAddr == regCmd);

   // Only the low two bits carry the opcode
   always_comb
   begin
      case (wrData[1:0])
         2'd1:    cmdOp = memRead;
         2'd2:    cmdOp = memWrite;
         default: cmdOp = memNone;
      endcase
   end

   // Staged address, byte at a time
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         memAddr <= '0;
      else if (wrStrobe && regAddr == regAddrHi)
         memAddr[15:8] <= wrData;
      else if (wrStrobe && regAddr == regAddrLo)
         memAddr[7:0] <= wrData;
   end

   // Staged data, loaded by the host or by a completed read
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         memData <= '0;
      else if (state == stReadCapture)
         memData <= ssramDIN;  // Read result takes priority
      else if (wrStrobe)
      begin
         case (regAddr)
            regData0: memData <= setWordByte(memData, 0, wrData);
            regData1: memData <= setWordByte(memData, 1, wrData);
            regData2: memData <= setWordByte(memData, 2, wrData);
            regData3: memData <= setWordByte(memData, 3, wrData);
            regData4: memData <= setWordByte(memData, 4, wrData);
            default:  ;
         endcase
      end
   end

   // Commands outside stIdle are dropped
   always_comb
   begin
      nextState = state;
      case (state)
         stIdle:
         begin
            if (cmdWrite && cmdOp == memRead)
               nextState = stReadAddr;
            else if (cmdWrite && cmdOp == memWrite)
               nextState = stWrite;
         end
         stReadAddr:    nextState = stReadCapture;  // SSRAM registers address
         stReadCapture: nextState = stIdle;
         stWrite:       nextState = stIdle;
         default:       nextState = stIdle;
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         state <= stIdle;
      else
         state <= nextState;
   end

   assign busy       = (state != stIdle);
   assign doneStrobe = (state == stReadCapture) || (state == stWrite);
   assign ssramWR    = (state == stWrite);           // Exactly one cycle
   assign ssramADDR  = memAddr[addrWidth-1:0];      // Upper bits alias
   assign ssramDOUT  = memData;

endmodule

// File: source/ks10Console.sv
`timescale 1ns/1ps

module ks10Console
#(
   parameter int addrWidth = 15  // 32K words
)
(
   input  logic             clk,
   input  logic             reset,
   input  cslPkg::cslByte_t cslADIN,
   input  logic             cslALE,
   input  logic             cslRD_N,
   input  logic             cslWR_N,
   input  ks10Pkg::word_t   ssramDIN,
   output cslPkg::cslByte_t cslADOUT,
   output logic             cslADOE,
   output logic             cslINTR_N,
   output logic             runLED,
   output logic [addrWidth-1:0] ssramADDR,
   output ks10Pkg::word_t   ssramDOUT,
   output logic             ssramWR
);

   import ks10Pkg::*;
   import cslPkg::*;

   cslByte_t               regAddr;    // Latched register address
   cslByte_t               wrData;     // Captured write byte
   logic                   wrStrobe;
   logic                   rdStrobe;
   logic                   rdActive;
   logic [statWidth-1:0]   statusReg;
   logic                   intrEnable;
   logic [memAddrBits-1:0] memAddr;    // Staged memory address
   word_t                  memData;    // Staged memory data
   logic                   busy;
   logic                   doneStrobe;

   // Console strobes and address latch
   cslBus bus0 (.clk, .reset, .cslADIN, .cslALE, .cslRD_N, .cslWR_N,
                .regAddr, .wrData, .wrStrobe, .rdStrobe, .rdActive);

   cslStatus status0 (.clk, .reset, .regAddr, .wrData, .wrStrobe,
                      .statusReg, .runLED, .intrEnable);

   // SSRAM single word sequencer
   memAccess #(.addrWidth(addrWidth)) mem0
   (
      .clk, .reset, .regAddr, .wrData, .wrStrobe,
      .memAddr, .memData, .busy, .doneStrobe,
      .ssramADDR, .ssramDOUT, .ssramDIN, .ssramWR
   );

   // Read-back and interrupt
   cslRespond respond0
   (
      .clk, .reset, .regAddr, .rdStrobe, .rdActive, .statusReg, .intrEnable,
      .memAddr, .memData, .busy, .doneStrobe,
      .cslADOUT, .cslADOE, .cslINTR_N
   );

endmodule

// File: testbench/ssramModel.sv
`timescale 1ns/1ps

module ssramModel
#(
   parameter int addrWidth = 15
)
(
   input  logic                 clk,
   input  logic [addrWidth-1:0] ssramADDR,
   input  ks10Pkg::word_t       ssramDOUT,  // Write data from the DUT
   input  logic                 ssramWR,
   output ks10Pkg::word_t       ssramDIN    // Read data to the DUT
);

   import ks10Pkg::*;

   word_t                mem [2**addrWidth];
   logic [addrWidth-1:0] addrReg;  // Address seen at the previous edge

   // Each word starts distinct, built from its full address
   initial
   begin
      for (int i = 0; i < 2**addrWidth; i++)
         mem[addrWidth'(i)] <= {4'h5, 16'(i), ~16'(i)};
   end

   always @(posedge clk)
   begin
      if (ssramWR)
         mem[ssramADDR] <= ssramDOUT;
      addrReg <= ssramADDR;  // Pipelined read
   end

   assign ssramDIN = mem[addrReg];

endmodule

// File: testbench/ks10Console_properties.sv
`timescale 1ns/1ps

module ks10Console_properties
(
   input logic clk,
   input logic reset,
   input logic cslWR_N,
   input logic cslADOE,
   input logic ssramWR,
   input logic cslINTR_N
);

   // Host never writes while the DUT drives AD
   oeDuringWrite: assert property (@(posedge clk) disable iff (reset)
                                   !cslWR_N |-> !cslADOE)
      else $error("cslADOE high while cslWR_N is low");

   // Write strobe is a single cycle
   singleWrite: assert property (@(posedge clk) disable iff (reset)
                                 ssramWR |=> !ssramWR)
      else $error("ssramWR high for two cycles");

   intrAfterReset: assert property (@(posedge clk) $fell(reset) |-> cslINTR_N)
      else $error("cslINTR_N low right after reset");

endmodule

// File: testbench/tbKs10Console.sv
`timescale 1ns/1ps

module tbKs10Console;

   import ks10Pkg::*;
   import cslPkg::*;

   localparam int addrWidth = 15;

   logic                 clk;
   logic                 reset;
   cslByte_t             cslADIN;
   logic                 cslALE;
   logic                 cslRD_N;
   logic                 cslWR_N;
   cslByte_t             cslADOUT;
   logic                 cslADOE;
   logic                 cslINTR_N;
   logic                 runLED;
   logic [addrWidth-1:0] ssramADDR;
   word_t                ssramDOUT;
   word_t                ssramDIN;
   logic                 ssramWR;
   logic                 intrAtRead;     // cslINTR_N as seen with the last read byte
   integer               seed = 32'h9b2e;
   word_t                expWords [5];   // Copy of what went into the SRAM
   logic [15:0]          testAddrs [5] = '{16'h0000, 16'h0001, 16'h1234, 16'h5a5a, 16'h7fff};

   ks10Console #(.addrWidth(addrWidth)) dut0
   (
      .clk, .reset, .cslADIN, .cslALE, .cslRD_N, .cslWR_N, .ssramDIN,
      .cslADOUT, .cslADOE, .cslINTR_N, .runLED, .ssramADDR, .ssramDOUT, .ssramWR
   );

   ssramModel #(.addrWidth(addrWidth)) sram0 (.clk, .ssramADDR, .ssramDOUT, .ssramWR, .ssramDIN);

   bind ks10Console ks10Console_properties props0
   (
      .clk, .reset, .cslWR_N, .cslADOE, .ssramWR, .cslINTR_N
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 100 MHz
   end

   task automatic stopOnFailure();
      $display("** FAIL **");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic reportTimeout(input string what);
      $display("Timed out at %0t ns while %s", $time, what);
      stopOnFailure();
   endtask

   task automatic checkByte(input cslByte_t got, input cslByte_t exp, input string what);
      if (got !== exp)
      begin
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         stopOnFailure();
      end
   endtask

   task automatic checkWord(input word_t got, input word_t exp, input string what);
      if (got !== exp)
      begin
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         stopOnFailure();
      end
   endtask

   task automatic checkLevel(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
         stopOnFailure();
      end
   endtask

   function automatic word_t randomWord();
      return word_t'({$random(seed), $random(seed)});
   endfunction

   // ALE pulse with the address held until the synchronizer catches up
   task automatic latchAddr(input cslByte_t addr);
      @(negedge clk);
      cslADIN = addr;
      cslALE  = 1'b1;
      repeat (3) @(negedge clk);
      cslALE = 1'b0;
      repeat (5) @(negedge clk);
   endtask

   task automatic cslWrite(input cslByte_t addr, input cslByte_t data);
      latchAddr(addr);
      cslADIN = data;
      cslWR_N = 1'b0;
      repeat (5) @(negedge clk);
      cslWR_N = 1'b1;              // Byte taken on this edge
      repeat (5) @(negedge clk);
   endtask

   task automatic cslRead(input cslByte_t addr, output cslByte_t data);
      int n;
      latchAddr(addr);
      cslRD_N = 1'b0;
      n = 0;
      while (!cslADOE && n < 20)
      begin
         @(negedge clk);
         n++;
      end
      if (!cslADOE)
         reportTimeout("waiting for cslADOE in a read");
      @(negedge clk);              // Read-back one cycle after OE
      data       = cslADOUT;
      intrAtRead = cslINTR_N;      // Before the read can acknowledge anything
      cslRD_N    = 1'b1;
      repeat (5) @(negedge clk);
   endtask

   task automatic expectRead(input cslByte_t addr, input cslByte_t exp, input string what);
      cslByte_t got;
      cslRead(addr, got);
      checkByte(got, exp, what);
   endtask

   // Polls regIntr and so acknowledges the done flag
   task automatic waitDone(output cslByte_t intr);
      int n;
      n = 0;
      cslRead(regIntr, intr);
      while (!intr[intrDoneBit] && n < 10)
      begin
         cslRead(regIntr, intr);
         n++;
      end
      if (!intr[intrDoneBit])
         reportTimeout("waiting for the done flag in regIntr");
   endtask

   task automatic setAddress(input logic [15:0] addr);
      cslWrite(regAddrHi, addr[15:8]);
      cslWrite(regAddrLo, addr[7:0]);
   endtask

   task automatic writeWord(input word_t w);
      cslWrite(regData0, {4'h0, w[35:32]});  // Top byte holds one nibble
      cslWrite(regData1, w[31:24]);
      cslWrite(regData2, w[23:16]);
      cslWrite(regData3, w[15:8]);
      cslWrite(regData4, w[7:0]);
   endtask

   task automatic readWord(output word_t w);
      cslByte_t b [5];
      for (int i = 0; i < wordBytes; i++)
         cslRead(cslByte_t'(regData0) + cslByte_t'(i), b[i]);
      w = {b[0][3:0], b[1], b[2], b[3], b[4]};
   endtask

   task automatic memWriteWord(input logic [15:0] addr, input word_t w);
      cslByte_t intr;
      setAddress(addr);
      writeWord(w);
      cslWrite(regCmd, cslByte_t'(memWrite));
      waitDone(intr);
   endtask

   task automatic memReadWord(input logic [15:0] addr, output word_t w);
      cslByte_t intr;
      setAddress(addr);
      cslWrite(regCmd, cslByte_t'(memRead));
      waitDone(intr);
      readWord(w);
   endtask

   task automatic testReset();
      word_t got;
      checkLevel(runLED, 1'b0, "runLED after reset");
      checkLevel(cslINTR_N, 1'b1, "cslINTR_N after reset");
      expectRead(regStat0, 8'h00, "regStat0 after reset");
      expectRead(regStat1, 8'h00, "regStat1 after reset");
      expectRead(regStat2, 8'h00, "regStat2 after reset");
      readWord(got);
      checkWord(got, '0, "data registers after reset");
   endtask

   task automatic testStatus();
      cslByte_t s0;
      cslByte_t s1;
      cslByte_t s2;
      s0 = cslByte_t'($random(seed));
      s1 = cslByte_t'($random(seed));
      s2 = (cslByte_t'($random(seed)) & 8'hfc) | 8'h01;  // Run on and intr enable off
      cslWrite(regStat0, s0);
      cslWrite(regStat1, s1);
      cslWrite(regStat2, s2);
      checkLevel(runLED, 1'b1, "runLED with run bit set");
      cslWrite(8'h40, 8'hff);                             // Unmapped
      expectRead(regStat0, s0, "regStat0");
      expectRead(regStat1, s1, "regStat1");
      expectRead(regStat2, s2, "regStat2");
      expectRead(8'h40, 8'h00, "unmapped address 0x40");
      cslWrite(regStat2, s2 & 8'hfe);
      checkLevel(runLED, 1'b0, "runLED with run bit clear");
   endtask

   task automatic testRoundTrip();
      word_t got;
      for (int i = 0; i < 5; i++)
      begin
         expWords[i] = randomWord();
         memWriteWord(testAddrs[i], expWords[i]);
      end
      for (int i = 0; i < 5; i++)
      begin
         writeWord(~expWords[i]);                         // Stale data first
         memReadWord(testAddrs[i], got);
         checkWord(got, expWords[i], "memory read back");
      end
   endtask

   task automatic testAliasing();
      word_t w;
      word_t got;
      w = randomWord();
      memWriteWord(16'(1 << addrWidth) | 16'h0123, w);
      memReadWord(16'h0123, got);
      checkWord(got, w, "aliased word at 0x0123");
   endtask

   task automatic testInterrupt();
      cslByte_t intr;
      int       n;
      cslWrite(regStat2, 8'h02);                          // Enable only
      setAddress(16'h0200);
      writeWord(randomWord());
      cslWrite(regCmd, cslByte_t'(memWrite));
      n = 0;
      while (cslINTR_N && n < 20)
      begin
         @(negedge clk);
         n++;
      end
      if (cslINTR_N)
         reportTimeout("waiting for cslINTR_N to fall");
      expectRead(regIntr, 8'h06, "regIntr with interrupt pending");
      checkLevel(cslINTR_N, 1'b1, "cslINTR_N after regIntr read");
      expectRead(regIntr, 8'h00, "regIntr after acknowledge");
      cslWrite(regStat2, 8'h00);
      cslWrite(regCmd, cslByte_t'(memRead));
      waitDone(intr);
      checkByte(intr, 8'h02, "regIntr with enable clear");  // Done but nothing pending
      checkLevel(intrAtRead, 1'b1, "cslINTR_N with enable clear and done set");
   endtask

   task automatic testIdleCommand();
      word_t w;
      word_t other;
      word_t got;
      w     = randomWord();
      other = randomWord();
      memWriteWord(16'h0456, w);
      writeWord(other);
      cslWrite(regCmd, cslByte_t'(memNone));
      expectRead(regIntr, 8'h00, "regIntr after memNone");
      readWord(got);
      checkWord(got, other, "data registers after memNone");
      memReadWord(16'h0456, got);
      checkWord(got, w, "SRAM word after memNone");
   endtask

   initial
   begin
      cslADIN = '0;
      cslALE  = 1'b0;
      cslRD_N = 1'b1;
      cslWR_N = 1'b1;
      reset   = 1'b1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      testReset();
      testStatus();
      testRoundTrip();
      testAliasing();
      testInterrupt();
      testIdleCommand();
      $display("** PASS **");
      $finish;
   end

endmodule

// File: filelist.f
common/ks10Pkg.sv
common/cslPkg.sv
console/cslBus.sv
console/cslStatus.sv
console/cslRespond.sv
source/memAccess.sv
source/ks10Console.sv
testbench/ssramModel.sv
testbench/ks10Console_properties.sv
testbench/tbKs10Console.sv

// File: Makefile
TOP = tbKs10Console
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; \
	elif grep -q '\*\* PASS \*\*' $(LOG); then echo "Simulation passed"; \
	else echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
